//--- tb_vp_top.sv
// directed testbench for vp_top at default parameters
// inputs change on the falling edge, registered outputs are read there as well
// apb outputs are combinational and are read a short settle time after the drive
// a small model of the table and the in-flight queue gives the expected values
`timescale 1ns/1ps

module tb_vp_top
   import vp_pkg::*;
();

   localparam int  TABLE_DEPTH = 128;
   localparam int  CONF_WIDTH  = 2;
   localparam int  QUEUE_DEPTH = 8;
   localparam int  IDX_W       = $clog2(TABLE_DEPTH);
   localparam int  CONF_MAX    = (1 << CONF_WIDTH) - 1;
   localparam int  CLK_PERIOD  = 20;
   localparam int  SETTLE      = 1;           // ns after a drive
   localparam int  TIMEOUT     = 50;          // cycles per wait
   localparam pc_t PC_A        = 31'h0000_0810;
   localparam pc_t PC_B        = 31'h0000_0a25;
   localparam pc_t PC_C        = 31'h0000_4040;  // base of the back-pressure run
   localparam pc_t PC_D        = 31'h0000_1066;
   localparam pc_t PC_E        = 31'h0000_2070;

   typedef struct packed {
      pc_t   pc;
      logic  hit;
      int    conf;
      word_t value;
      logic  used;
   } inflight_t;

   logic      clk;
   logic      reset_i;
   logic      dec_valid_i;
   pc_t       dec_pc_i;
   logic      dec_ready_o;
   logic      pred_valid_o;
   logic      pred_use_o;
   word_t     pred_value_o;
   logic      ret_valid_i;
   word_t     ret_result_i;
   logic      pipe_flush_i;
   logic      vp_flush_o;
   pc_t       vp_flush_pc_o;
   logic      psel_i;
   logic      penable_i;
   logic      pwrite_i;
   apb_addr_t paddr_i;
   word_t     pwdata_i;
   word_t     prdata_o;
   logic      pready_o;
   logic      pslverr_o;

   //*********************************************************************
   // reference model state
   //*********************************************************************
   logic      m_valid [TABLE_DEPTH];
   pc_t       m_pc    [TABLE_DEPTH];
   word_t     m_value [TABLE_DEPTH];
   int        m_conf  [TABLE_DEPTH];
   logic      m_enable;
   int        m_thresh;
   word_t     m_used_cnt;
   word_t     m_misp_cnt;
   inflight_t pend [$];   // looked up, not yet retired

   word_t rand_state;
   word_t a_value;        // last value trained into PC_A
   word_t b_value;        // last value trained into PC_B
   int    checks;
   int    failures;
   int    tests;

   vp_top uut (
      .clk(clk), .reset_i(reset_i),
      .dec_valid_i(dec_valid_i), .dec_pc_i(dec_pc_i), .dec_ready_o(dec_ready_o),
      .pred_valid_o(pred_valid_o), .pred_use_o(pred_use_o), .pred_value_o(pred_value_o),
      .ret_valid_i(ret_valid_i), .ret_result_i(ret_result_i), .pipe_flush_i(pipe_flush_i),
      .vp_flush_o(vp_flush_o), .vp_flush_pc_o(vp_flush_pc_o),
      .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i), .paddr_i(paddr_i),
      .pwdata_i(pwdata_i), .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic word_t next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   function automatic int index_of(input pc_t pc);
      return int'(pc[IDX_W:1]);
   endfunction

   // what the table should answer for this pc right now
   function automatic inflight_t predict(input pc_t pc);
      inflight_t e;
      int        idx;
      idx     = index_of(pc);
      e.pc    = pc;
      e.hit   = m_valid[idx] && (m_pc[idx] == pc);
      e.conf  = m_conf[idx];
      e.value = m_value[idx];
      e.used  = e.hit && (m_conf[idx] >= m_thresh) && m_enable;
      return e;
   endfunction

   task automatic clear_model();
      for (int i = 0; i < TABLE_DEPTH; i++) begin
         m_valid[i] = 1'b0;
         m_pc[i]    = '0;
         m_value[i] = '0;
         m_conf[i]  = 0;
      end
      m_enable   = VP_CTRL_RESET[0];
      m_thresh   = CONF_MAX;
      m_used_cnt = '0;
      m_misp_cnt = '0;
      pend.delete();
   endtask

   task automatic compare_value(input string name, input word_t got, input word_t exp);
      checks++;
      assert (got === exp) else begin
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         failures++;
      end
   endtask

   task automatic confirm_wait(input logic ok, input string what);
      checks++;
      assert (ok) else begin
         $display("at %0t ns: gave up waiting for %s", $time, what);
         failures++;
      end
   endtask

   task automatic report_test(input string name, input int fails_before);
      tests++;
      if (failures == fails_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d failures", name, failures - fails_before);
      end
   endtask

   //*********************************************************************
   // apb, decode and retire drivers
   //*********************************************************************
   task automatic bus_transfer(input apb_addr_t addr, input logic write, input word_t wdata,
                               output word_t rdata, output logic err);
      int waited;
      waited = 0;
      @(negedge clk);
      psel_i    = 1'b1;            // setup phase
      penable_i = 1'b0;
      pwrite_i  = write;
      paddr_i   = addr;
      pwdata_i  = wdata;
      @(negedge clk);
      penable_i = 1'b1;            // access phase
      #(SETTLE);
      while (!pready_o && waited < TIMEOUT) begin
         @(negedge clk);
         #(SETTLE);
         waited++;
      end
      confirm_wait(pready_o, "pready_o");
      rdata = prdata_o;
      err   = pslverr_o;
      @(negedge clk);
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic write_reg(input apb_addr_t addr, input word_t data, input logic exp_err);
      word_t rdata;
      logic  err;
      bus_transfer(addr, 1'b1, data, rdata, err);
      compare_value("pslverr_o", err, exp_err);
   endtask

   task automatic read_reg(input apb_addr_t addr, input word_t exp_data, input logic exp_err);
      word_t rdata;
      logic  err;
      bus_transfer(addr, 1'b0, '0, rdata, err);
      compare_value("pslverr_o", err, exp_err);
      if (!exp_err) begin
         compare_value("prdata_o", rdata, exp_data);  // data undefined on an error
      end
   endtask

   task automatic issue_decode(input pc_t pc, output logic seen_use);
      inflight_t e;
      int        waited;
      waited = 0;
      @(negedge clk);
      dec_valid_i = 1'b1;
      dec_pc_i    = pc;
      while (!dec_ready_o && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      confirm_wait(dec_ready_o, "dec_ready_o");
      e = predict(pc);             // table as seen at the accept edge
      @(negedge clk);
      dec_valid_i = 1'b0;
      compare_value("pred_valid_o", pred_valid_o, 1'b1);
      compare_value("pred_use_o", pred_use_o, e.used);
      if (e.hit) begin
         compare_value("pred_value_o", pred_value_o, e.value);
      end
      pend.push_back(e);
      seen_use = pred_use_o;
   endtask

   task automatic retire_one(input word_t result);
      inflight_t e;
      logic      same;
      logic      misp;
      int        idx;
      checks++;
      assert (pend.size() != 0) else begin
         $display("at %0t ns: retire asked for with nothing in flight", $time);
         failures++;
      end
      if (pend.size() == 0) return;
      e    = pend.pop_front();
      same = e.hit && (e.value == result);
      misp = e.used && !same;
      idx  = index_of(e.pc);
      m_valid[idx] = 1'b1;
      m_pc[idx]    = e.pc;
      m_value[idx] = result;
      m_conf[idx]  = !same ? 0 : (e.conf == CONF_MAX) ? CONF_MAX : e.conf + 1;
      if (e.used) m_used_cnt = m_used_cnt + 1;
      if (misp)   m_misp_cnt = m_misp_cnt + 1;
      @(negedge clk);
      ret_valid_i  = 1'b1;
      ret_result_i = result;
      @(negedge clk);
      ret_valid_i  = 1'b0;
      compare_value("vp_flush_o", vp_flush_o, misp);
      if (misp) begin
         compare_value("vp_flush_pc_o", vp_flush_pc_o, e.pc);
         pend.delete();            // flush drops everything in flight
         @(negedge clk);           // let the flush edge go by
      end
   endtask

   // flush while e1 holds the last decode, with one more decode offered
   task automatic flush_pipe(input pc_t pc);
      pipe_flush_i = 1'b1;
      dec_valid_i  = 1'b1;
      dec_pc_i     = pc;
      @(negedge clk);
      pipe_flush_i = 1'b0;
      dec_valid_i  = 1'b0;
      pend.delete();
   endtask

   //*********************************************************************
   // directed tests
   //*********************************************************************
   task automatic reset_values();
      int f0;
      f0 = failures;
      compare_value("pred_valid_o", pred_valid_o, 1'b0);
      compare_value("pred_use_o", pred_use_o, 1'b0);
      compare_value("vp_flush_o", vp_flush_o, 1'b0);
      compare_value("pready_o", pready_o, 1'b0);
      compare_value("pslverr_o", pslverr_o, 1'b0);
      compare_value("dec_ready_o", dec_ready_o, 1'b1);
      read_reg(VP_CTRL_ADDR, 32'h1, 1'b0);
      read_reg(VP_THRESH_ADDR, CONF_MAX, 1'b0);
      read_reg(VP_USED_ADDR, 32'h0, 1'b0);
      read_reg(VP_MISP_ADDR, 32'h0, 1'b0);
      report_test("after reset", f0);
   endtask

   task automatic train_pc();
      int   f0;
      logic seen;
      f0      = failures;
      a_value = next_rand();
      for (int i = 0; i < CONF_MAX + 3; i++) begin
         issue_decode(PC_A, seen);
         compare_value("pred_use_o", seen, i > CONF_MAX);  // install, then count up
         if (i > CONF_MAX) compare_value("pred_value_o", pred_value_o, a_value);
         retire_one(a_value);
      end
      report_test("training", f0);
   endtask

   task automatic mispredict_flush();
      int    f0;
      logic  seen;
      word_t bad;
      f0  = failures;
      bad = a_value ^ 32'h8000_0001;
      issue_decode(PC_A, seen);
      compare_value("pred_use_o", seen, 1'b1);
      retire_one(bad);             // flush checked one cycle later
      a_value = bad;
      issue_decode(PC_A, seen);
      compare_value("pred_use_o", seen, 1'b0);
      retire_one(a_value);
      read_reg(VP_MISP_ADDR, 32'h1, 1'b0);
      read_reg(VP_USED_ADDR, m_used_cnt, 1'b0);
      report_test("misprediction", f0);
   endtask

   task automatic register_control();
      int   f0;
      logic seen;
      f0 = failures;
      write_reg(VP_THRESH_ADDR, 32'h1, 1'b0);
      m_thresh = 1;
      read_reg(VP_THRESH_ADDR, 32'h1, 1'b0);
      b_value = next_rand();
      issue_decode(PC_B, seen);    // miss, installs
      retire_one(b_value);
      issue_decode(PC_B, seen);
      compare_value("pred_use_o", seen, 1'b0);
      retire_one(b_value);         // one matching retire
      issue_decode(PC_B, seen);
      compare_value("pred_use_o", seen, 1'b1);
      retire_one(b_value);
      write_reg(VP_CTRL_ADDR, 32'h0, 1'b0);
      m_enable = 1'b0;
      issue_decode(PC_A, seen);    // trained but predictor off
      compare_value("pred_use_o", seen, 1'b0);
      retire_one(a_value);
      write_reg(VP_CTRL_ADDR, 32'h1, 1'b0);
      m_enable = 1'b1;
      write_reg(VP_USED_ADDR, 32'h5a5a_5a5a, 1'b0);
      m_used_cnt = '0;
      read_reg(VP_USED_ADDR, 32'h0, 1'b0);
      read_reg(4'h2, 32'h0, 1'b1);
      write_reg(4'h6, 32'hffff_ffff, 1'b1);
      read_reg(VP_CTRL_ADDR, 32'h1, 1'b0);  // bad write left ctrl alone
      report_test("register control", f0);
   endtask

   task automatic back_pressure();
      int   f0;
      logic seen;
      f0 = failures;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         issue_decode(PC_C + pc_t'(i), seen);
      end
      compare_value("dec_ready_o", dec_ready_o, 1'b0);
      @(negedge clk);
      dec_valid_i = 1'b1;          // offered while blocked
      dec_pc_i    = PC_D;
      @(negedge clk);
      dec_valid_i = 1'b0;
      compare_value("pred_valid_o", pred_valid_o, 1'b0);
      compare_value("dec_ready_o", dec_ready_o, 1'b0);
      retire_one(next_rand());
      compare_value("dec_ready_o", dec_ready_o, 1'b1);
      while (pend.size() != 0) begin
         retire_one(next_rand());
      end
      report_test("back-pressure", f0);
   endtask

   task automatic pipeline_flush();
      int   f0;
      logic seen;
      f0 = failures;
      issue_decode(PC_D, seen);
      issue_decode(PC_E, seen);
      flush_pipe(PC_A);            // e1 and the offered decode both dropped
      compare_value("pred_valid_o", pred_valid_o, 1'b0);
      issue_decode(PC_B, seen);
      compare_value("pred_use_o", seen, 1'b1);
      retire_one(b_value ^ 32'h0000_00ff);  // must hit PC_B, not the dropped ones
      compare_value("vp_flush_pc_o", vp_flush_pc_o, PC_B);
      issue_decode(PC_D, seen);
      retire_one(next_rand());
      compare_value("vp_flush_o", vp_flush_o, 1'b0);
      read_reg(VP_MISP_ADDR, m_misp_cnt, 1'b0);
      report_test("pipeline flush", f0);
   endtask

   initial begin
      clk          = 1'b0;
      reset_i      = 1'b1;
      dec_valid_i  = 1'b0;
      dec_pc_i     = '0;
      ret_valid_i  = 1'b0;
      ret_result_i = '0;
      pipe_flush_i = 1'b0;
      psel_i       = 1'b0;
      penable_i    = 1'b0;
      pwrite_i     = 1'b0;
      paddr_i      = '0;
      pwdata_i     = '0;
      rand_state   = 32'h38c1;
      checks       = 0;
      failures     = 0;
      tests        = 0;
      clear_model();
      repeat (3) @(negedge clk);
      reset_i = 1'b0;
      reset_values();
      train_pc();
      mispredict_flush();
      register_control();
      back_pressure();
      pipeline_flush();
      $display("%0d tests, %0d checks, %0d failures", tests, checks, failures);
      if (failures == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- vp_apb_regs.sv
// apb control and statistics registers, one setup and one access phase
// pready is high in every access phase, no wait states
// unknown offsets answer with pslverr, writes to the counters clear them
`timescale 1ns/1ps

module vp_apb_regs
   import vp_pkg::*;
#(
   parameter int CONF_WIDTH = 2
) (
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  apb_addr_t             paddr_i,
   input  word_t                 pwdata_i,
   output word_t                 prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,
   input  logic                  stat_used_i,
   input  logic                  stat_misp_i,
   output logic                  enable_o,
   output logic [CONF_WIDTH-1:0] threshold_o
);

   logic  access;   // apb access phase
   logic  addr_ok;  // offset is mapped
   logic  wr_en;    // legal write this cycle
   word_t used_q;   // used predictions retired
   word_t misp_q;   // mispredictions

   function automatic word_t sat_inc(word_t cnt);
      return (&cnt) ? cnt : cnt + 32'd1;
   endfunction

   assign access    = psel_i & penable_i;
   assign addr_ok   = paddr_i inside {VP_CTRL_ADDR, VP_THRESH_ADDR, VP_USED_ADDR,
                                      VP_MISP_ADDR};
   assign wr_en     = access & pwrite_i & addr_ok;
   assign pready_o  = access;
   assign pslverr_o = access & ~addr_ok;

   //*********************************************************************
   // control
   //*********************************************************************
   always_ff @(posedge clk) begin
      if (reset_i) begin
         enable_o    <= VP_CTRL_RESET[0];
         threshold_o <= '1;                                 // strictest setting
      end else if (wr_en && paddr_i == VP_CTRL_ADDR) begin
         enable_o    <= pwdata_i[0];
      end else if (wr_en && paddr_i == VP_THRESH_ADDR) begin
         threshold_o <= pwdata_i[CONF_WIDTH-1:0];
      end
   end

   //*********************************************************************
   // statistics, saturating
   //*********************************************************************
   always_ff @(posedge clk) begin
      if (reset_i || (wr_en && paddr_i == VP_USED_ADDR)) begin
         used_q <= '0;
      end else if (stat_used_i) begin
         used_q <= sat_inc(used_q);
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i || (wr_en && paddr_i == VP_MISP_ADDR)) begin
         misp_q <= '0;
      end else if (stat_misp_i) begin
         misp_q <= sat_inc(misp_q);
      end
   end

   always_comb begin
      case (paddr_i)
         VP_CTRL_ADDR:   prdata_o = word_t'(enable_o);
         VP_THRESH_ADDR: prdata_o = word_t'(threshold_o);
         VP_USED_ADDR:   prdata_o = used_q;
         VP_MISP_ADDR:   prdata_o = misp_q;
         default:        prdata_o = '0;                     // unmapped reads zero
      endcase
   end

endmodule

//--- vp_if.sv
// stage links of the value predictor
// CONF_WIDTH must match the width used by the table
// queue space counts the entry sitting in e1
`timescale 1ns/1ps

interface vp_pred_if
   import vp_pkg::*;
#(
   parameter int CONF_WIDTH = 2
) ();
   logic                  valid;   // e1 prediction present
   pc_t                   pc;      // pc of the e1 instruction
   logic                  hit;     // tag matched at lookup
   logic [CONF_WIDTH-1:0] conf;    // confidence read at lookup
   word_t                 value;   // predicted value
   logic                  use_vp;  // prediction handed to the pipe
   logic                  space;   // room for one more past e1

   modport lookup (output valid, pc, hit, conf, value, use_vp, input space);
   modport queue  (input valid, pc, hit, conf, value, use_vp, output space);
endinterface

interface vp_retire_if
   import vp_pkg::*;
#(
   parameter int CONF_WIDTH = 2
) ();
   logic                  head_valid;  // oldest in-flight entry present
   pc_t                   head_pc;
   logic                  head_hit;
   logic [CONF_WIDTH-1:0] head_conf;
   word_t                 head_value;
   logic                  head_use;
   logic                  pop;         // only while head_valid
   logic                  clear;       // drop everything in flight

   modport queue   (output head_valid, head_pc, head_hit, head_conf, head_value,
                    head_use, input pop, clear);
   modport resolve (input head_valid, head_pc, head_hit, head_conf, head_value,
                    head_use, output pop, clear);
endinterface

//--- vp_inflight_queue.sv
// in-order queue of looked-up instructions waiting for retire
// every valid e1 entry is pushed, the lookup stage never overfills it
// clear wins over push and pop at the same edge
`timescale 1ns/1ps

module vp_inflight_queue
   import vp_pkg::*;
#(
   parameter  int QUEUE_DEPTH = 8,
   parameter  int CONF_WIDTH  = 2,
   localparam int PTR_W       = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1,
   localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1)
) (
   input  logic       clk,
   input  logic       reset_i,
   vp_pred_if.queue   pred,
   vp_retire_if.queue ret
);

   logic                  push;
   logic                  pop;
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [CNT_W-1:0]      count;                   // entries held
   logic [CNT_W:0]        occupancy;               // held plus e1
   pc_t                   pc_q    [QUEUE_DEPTH];
   logic                  hit_q   [QUEUE_DEPTH];
   logic [CONF_WIDTH-1:0] conf_q  [QUEUE_DEPTH];
   word_t                 value_q [QUEUE_DEPTH];
   logic                  use_q   [QUEUE_DEPTH];

   function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign push = pred.valid;
   assign pop  = ret.pop;

   assign occupancy  = {1'b0, count} + (CNT_W + 1)'(pred.valid);
   assign pred.space = occupancy < QUEUE_DEPTH;

   always_ff @(posedge clk) begin
      if (reset_i || ret.clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop)  rd_ptr <= ptr_inc(rd_ptr);
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         pc_q[wr_ptr]    <= pred.pc;
         hit_q[wr_ptr]   <= pred.hit;
         conf_q[wr_ptr]  <= pred.conf;
         value_q[wr_ptr] <= pred.value;
         use_q[wr_ptr]   <= pred.use_vp;
      end
   end

   // oldest entry
   assign ret.head_valid = count != '0;
   assign ret.head_pc    = pc_q[rd_ptr];
   assign ret.head_hit   = hit_q[rd_ptr];
   assign ret.head_conf  = conf_q[rd_ptr];
   assign ret.head_value = value_q[rd_ptr];
   assign ret.head_use   = use_q[rd_ptr];

   // decode gating upstream keeps a slot free for the e1 entry
   a_no_push_full: assert property (@(posedge clk) disable iff (reset_i || ret.clear)
      push |-> count < QUEUE_DEPTH);

   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset_i || ret.clear)
      pop |-> count != '0);

endmodule

//--- vp_lookup.sv
// decode stage lookup, prediction shows up in e1 one cycle after accept
// decode is held off while the queue cannot take the e1 entry
// a flush drops the e1 entry at the same edge
`timescale 1ns/1ps

module vp_lookup
   import vp_pkg::*;
#(
   parameter  int TABLE_DEPTH = 128,
   parameter  int CONF_WIDTH  = 2,
   localparam int IDX_W       = $clog2(TABLE_DEPTH),
   localparam int TAG_W       = 31 - IDX_W
) (
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic                  dec_valid_i,
   input  pc_t                   dec_pc_i,
   output logic                  dec_ready_o,
   input  logic                  flush_i,
   input  logic                  enable_i,
   input  logic [CONF_WIDTH-1:0] threshold_i,
   output logic [IDX_W-1:0]      rd_index_o,
   input  logic                  rd_valid_i,
   input  logic [TAG_W-1:0]      rd_tag_i,
   input  word_t                 rd_value_i,
   input  logic [CONF_WIDTH-1:0] rd_conf_i,
   vp_pred_if.lookup             pred
);

   logic dec_fire;  // decode accepted this cycle
   logic tag_hit;   // valid entry with matching tag
   logic use_d;     // confident enough to hand out

   assign dec_ready_o = pred.space;
   assign dec_fire    = dec_valid_i & dec_ready_o;

   // low pc bits index, the rest is the tag
   assign rd_index_o = dec_pc_i[IDX_W:1];
   assign tag_hit    = rd_valid_i & (rd_tag_i == dec_pc_i[31:IDX_W+1]);
   assign use_d      = tag_hit & (rd_conf_i >= threshold_i) & enable_i;

   //*********************************************************************
   // e1 stage
   //*********************************************************************
   always_ff @(posedge clk) begin
      if (reset_i || flush_i) begin
         pred.valid  <= 1'b0;
         pred.use_vp <= 1'b0;
      end else begin
         pred.valid  <= dec_fire;
         pred.use_vp <= dec_fire & use_d;
      end
   end

   always_ff @(posedge clk) begin
      if (dec_fire) begin
         pred.pc    <= dec_pc_i;
         pred.hit   <= tag_hit;
         pred.conf  <= rd_conf_i;    // kept for training at retire
         pred.value <= rd_value_i;
      end
   end

   // a used prediction always comes from a live hit
   a_use_needs_hit: assert property (@(posedge clk) disable iff (reset_i)
      pred.use_vp |-> pred.valid && pred.hit);

endmodule

//--- vp_pkg.sv
// types and apb register map shared by every block of the value predictor
// pcs are halfword aligned so bit 0 is never carried
// offsets are byte offsets inside a 16 byte apb window
package vp_pkg;

   typedef logic [31:0] word_t;      // result value
   typedef logic [31:1] pc_t;        // halfword aligned pc
   typedef logic [3:0]  apb_addr_t;  // apb byte offset

   //*********************************************************************
   // apb register map
   //*********************************************************************
   localparam apb_addr_t VP_CTRL_ADDR   = 4'h0;  // bit 0 enable
   localparam apb_addr_t VP_THRESH_ADDR = 4'h4;  // confidence threshold
   localparam apb_addr_t VP_USED_ADDR   = 4'h8;  // used predictions retired
   localparam apb_addr_t VP_MISP_ADDR   = 4'hC;  // mispredictions

   localparam word_t VP_CTRL_RESET = 32'h0000_0001;  // predictor on out of reset

endpackage

//--- vp_resolve.sv
// retire compare, table training and misprediction flush
// retires arrive in program order and match the queue head
// flush and its pc are registered, one cycle after the bad retire
`timescale 1ns/1ps

module vp_resolve
   import vp_pkg::*;
#(
   parameter  int TABLE_DEPTH = 128,
   parameter  int CONF_WIDTH  = 2,
   localparam int IDX_W       = $clog2(TABLE_DEPTH),
   localparam int TAG_W       = 31 - IDX_W
) (
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic                  flush_i,
   input  logic                  ret_valid_i,
   input  word_t                 ret_result_i,
   vp_retire_if.resolve          ret,
   output logic                  wr_en_o,
   output logic [IDX_W-1:0]      wr_index_o,
   output logic [TAG_W-1:0]      wr_tag_o,
   output word_t                 wr_value_o,
   output logic [CONF_WIDTH-1:0] wr_conf_o,
   output logic                  vp_flush_o,
   output pc_t                   vp_flush_pc_o,
   output logic                  stat_used_o,
   output logic                  stat_misp_o
);

   logic value_match;  // hit and same value again
   logic misp;         // used prediction turned out wrong

   assign value_match = ret.head_hit & (ret.head_value == ret_result_i);
   assign misp        = ret_valid_i & ret.head_use & ~value_match;

   assign ret.pop   = ret_valid_i;
   assign ret.clear = flush_i;     // pipe flush or our own flush

   //*********************************************************************
   // training, lands at the retire edge
   //*********************************************************************
   assign wr_en_o    = ret_valid_i;
   assign wr_index_o = ret.head_pc[IDX_W:1];
   assign wr_tag_o   = ret.head_pc[31:IDX_W+1];  // retag on a miss
   assign wr_value_o = ret_result_i;
   assign wr_conf_o  = !value_match     ? '0 :            // restart on change
                       (&ret.head_conf) ? ret.head_conf : // saturate
                                          ret.head_conf + 1'b1;

   assign stat_used_o = ret_valid_i & ret.head_use;
   assign stat_misp_o = misp;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         vp_flush_o <= 1'b0;
      end else begin
         vp_flush_o <= misp;
      end
   end

   always_ff @(posedge clk) begin
      if (misp) begin
         vp_flush_pc_o <= ret.head_pc;  // refetch the bad instruction
      end
   end

   // the pipe never retires more than was looked up
   a_retire_has_head: assert property (@(posedge clk) disable iff (reset_i)
      ret_valid_i |-> ret.head_valid);

endmodule

//--- vp_table.sv
// direct mapped last value table, TABLE_DEPTH must be a power of two
// read is combinational, a write lands at the clock edge
// reset clears the valid bits only
`timescale 1ns/1ps

module vp_table
   import vp_pkg::*;
#(
   parameter  int TABLE_DEPTH = 128,
   parameter  int CONF_WIDTH  = 2,
   localparam int IDX_W       = $clog2(TABLE_DEPTH),
   localparam int TAG_W       = 31 - IDX_W
) (
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic [IDX_W-1:0]      rd_index_i,
   output logic                  rd_valid_o,
   output logic [TAG_W-1:0]      rd_tag_o,
   output word_t                 rd_value_o,
   output logic [CONF_WIDTH-1:0] rd_conf_o,
   input  logic                  wr_en_i,
   input  logic [IDX_W-1:0]      wr_index_i,
   input  logic [TAG_W-1:0]      wr_tag_i,
   input  word_t                 wr_value_i,
   input  logic [CONF_WIDTH-1:0] wr_conf_i
);

   logic [TABLE_DEPTH-1:0] valid_q;               // entry written since reset
   logic [TAG_W-1:0]       tag_q   [TABLE_DEPTH]; // upper pc bits
   word_t                  value_q [TABLE_DEPTH]; // last retired result
   logic [CONF_WIDTH-1:0]  conf_q  [TABLE_DEPTH]; // repeat count

   always_ff @(posedge clk) begin
      if (reset_i) begin
         valid_q <= '0;
      end else if (wr_en_i) begin
         valid_q[wr_index_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         tag_q[wr_index_i]   <= wr_tag_i;
         value_q[wr_index_i] <= wr_value_i;
         conf_q[wr_index_i]  <= wr_conf_i;
      end
   end

   assign rd_valid_o = valid_q[rd_index_i];
   assign rd_tag_o   = tag_q[rd_index_i];
   assign rd_value_o = value_q[rd_index_i];
   assign rd_conf_o  = conf_q[rd_index_i];

endmodule

//--- vp_top.f
vp_pkg.sv
vp_if.sv
vp_table.sv
vp_lookup.sv
vp_inflight_queue.sv
vp_resolve.sv
vp_apb_regs.sv
vp_top.sv
tb_vp_top.sv

//--- vp_top.sv
// single slot last value predictor with apb control
// TABLE_DEPTH must be a power of two, QUEUE_DEPTH bounds instructions in flight
// pipe_flush_i and vp_flush_o both empty the e1 stage and the queue
`timescale 1ns/1ps

module vp_top
   import vp_pkg::*;
#(
   parameter  int TABLE_DEPTH = 128,
   parameter  int CONF_WIDTH  = 2,
   parameter  int QUEUE_DEPTH = 8,
   localparam int IDX_W       = $clog2(TABLE_DEPTH),
   localparam int TAG_W       = 31 - IDX_W
) (
   input  logic      clk,
   input  logic      reset_i,
   // decode side
   input  logic      dec_valid_i,
   input  pc_t       dec_pc_i,
   output logic      dec_ready_o,
   output logic      pred_valid_o,
   output logic      pred_use_o,
   output word_t     pred_value_o,
   // retire side
   input  logic      ret_valid_i,
   input  word_t     ret_result_i,
   input  logic      pipe_flush_i,
   output logic      vp_flush_o,
   output pc_t       vp_flush_pc_o,
   // apb
   input  logic      psel_i,
   input  logic      penable_i,
   input  logic      pwrite_i,
   input  apb_addr_t paddr_i,
   input  word_t     pwdata_i,
   output word_t     prdata_o,
   output logic      pready_o,
   output logic      pslverr_o
);

   logic [IDX_W-1:0]      rd_index;
   logic                  rd_valid;
   logic [TAG_W-1:0]      rd_tag;
   word_t                 rd_value;
   logic [CONF_WIDTH-1:0] rd_conf;
   logic                  wr_en;
   logic [IDX_W-1:0]      wr_index;
   logic [TAG_W-1:0]      wr_tag;
   word_t                 wr_value;
   logic [CONF_WIDTH-1:0] wr_conf;
   logic                  stat_used;
   logic                  stat_misp;
   logic                  enable;
   logic [CONF_WIDTH-1:0] threshold;
   logic                  flush;      // any flush, lookup and queue

   vp_pred_if   #(.CONF_WIDTH(CONF_WIDTH)) pred_if ();
   vp_retire_if #(.CONF_WIDTH(CONF_WIDTH)) ret_if ();

   assign flush        = pipe_flush_i | vp_flush_o;
   assign pred_valid_o = pred_if.valid;
   assign pred_use_o   = pred_if.use_vp;
   assign pred_value_o = pred_if.value;

   vp_table #(.TABLE_DEPTH(TABLE_DEPTH), .CONF_WIDTH(CONF_WIDTH)) table_u (
      .clk(clk), .reset_i(reset_i),
      .rd_index_i(rd_index), .rd_valid_o(rd_valid), .rd_tag_o(rd_tag),
      .rd_value_o(rd_value), .rd_conf_o(rd_conf),
      .wr_en_i(wr_en), .wr_index_i(wr_index), .wr_tag_i(wr_tag),
      .wr_value_i(wr_value), .wr_conf_i(wr_conf)
   );

   vp_lookup #(.TABLE_DEPTH(TABLE_DEPTH), .CONF_WIDTH(CONF_WIDTH)) lookup_u (
      .clk(clk), .reset_i(reset_i),
      .dec_valid_i(dec_valid_i), .dec_pc_i(dec_pc_i), .dec_ready_o(dec_ready_o),
      .flush_i(flush), .enable_i(enable), .threshold_i(threshold),
      .rd_index_o(rd_index), .rd_valid_i(rd_valid), .rd_tag_i(rd_tag),
      .rd_value_i(rd_value), .rd_conf_i(rd_conf),
      .pred(pred_if.lookup)
   );

   vp_inflight_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .CONF_WIDTH(CONF_WIDTH)) queue_u (
      .clk(clk), .reset_i(reset_i),
      .pred(pred_if.queue), .ret(ret_if.queue)
   );

   vp_resolve #(.TABLE_DEPTH(TABLE_DEPTH), .CONF_WIDTH(CONF_WIDTH)) resolve_u (
      .clk(clk), .reset_i(reset_i), .flush_i(flush),
      .ret_valid_i(ret_valid_i), .ret_result_i(ret_result_i), .ret(ret_if.resolve),
      .wr_en_o(wr_en), .wr_index_o(wr_index), .wr_tag_o(wr_tag),
      .wr_value_o(wr_value), .wr_conf_o(wr_conf),
      .vp_flush_o(vp_flush_o), .vp_flush_pc_o(vp_flush_pc_o),
      .stat_used_o(stat_used), .stat_misp_o(stat_misp)
   );

   vp_apb_regs #(.CONF_WIDTH(CONF_WIDTH)) regs_u (
      .clk(clk), .reset_i(reset_i),
      .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
      .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
      .pready_o(pready_o), .pslverr_o(pslverr_o),
      .stat_used_i(stat_used), .stat_misp_i(stat_misp),
      .enable_o(enable), .threshold_o(threshold)
   );

endmodule
